// File: build.f
+incdir+hw
hw/rob_pkg.sv
hw/isa_pkg.sv
hw/arch_regfile.sv
hw/dispatch_ctrl.sv
hw/reorder_buffer.sv
hw/alu_unit.sv
hw/mul_pipe.sv
hw/div_unit.sv
hw/ooo_backend.sv
tests/ooo_backend_tb.sv

// File: hw/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_macros.svh"

module alu_unit (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    flush,
    input  wire                    issue,
    input  wire  isa_pkg::alu_op_e op,
    input  wire  [`XLEN-1:0]       a,
    input  wire  [`XLEN-1:0]       b,
    input  wire  rob_pkg::rob_tag_t tag,
    output logic                   done,
    output rob_pkg::rob_tag_t      done_tag,
    output logic [`XLEN-1:0]       value
);
    import isa_pkg::*;

    logic [`XLEN-1:0] result;

    always_comb begin
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = '0;       // OP_NONE
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else if (flush) begin
            done <= 1'b0;
        end else begin
            done <= issue;              // One cycle after issue
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            done_tag <= tag;
            value    <= result;
        end
    end

endmodule

`default_nettype wire

// File: hw/arch_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_macros.svh"

module arch_regfile (
    input  wire              clk,
    input  wire              rst,
    input  wire  [4:0]       rs1,
    input  wire  [4:0]       rs2,
    input  wire              wr_en,     // Commit write strobe
    input  wire  [4:0]       wr_addr,
    input  wire  [`XLEN-1:0] wr_data,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin   // x0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hw/backend_macros.svh
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

`define XLEN       32   // Data path width
`define NUM_REGS   32   // Architectural registers, x0 included
`define ROB_DEPTH  16   // Power of two so pointers wrap freely
`define ROB_TAG_W  4    // log2 of ROB_DEPTH
`define MUL_STAGES 3    // Issue to done latency of the multiplier

`endif

// File: hw/dispatch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_macros.svh"

module dispatch_ctrl (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   flush,
    input  wire  [31:0]           inst,
    input  wire                   inst_valid,
    input  wire  [`NUM_REGS-1:0]  pending_mask,   // Registers with an uncommitted writer
    input  wire                   full,
    input  wire  rob_pkg::rob_tag_t alloc_tag,
    input  wire                   div_busy,
    input  wire  [`XLEN-1:0]      rs1_data,
    input  wire  [`XLEN-1:0]      rs2_data,
    output logic                  inst_ready,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic                  alloc,
    output logic [4:0]            alloc_dest,
    output logic                  alloc_reg_write,
    output logic                  alu_issue,
    output isa_pkg::alu_op_e      alu_op,
    output logic                  mul_issue,
    output logic                  div_issue,
    output logic                  div_rem,        // REMU rather than DIVU
    output logic [`XLEN-1:0]      op_a,
    output logic [`XLEN-1:0]      op_b,
    output rob_pkg::rob_tag_t     issue_tag
);
    import isa_pkg::*;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;   // SUB
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;   // M extension

    disp_state_e state;
    logic [31:0] held;                  // Holding register
    fu_sel_e     fu;
    logic        writes;
    logic        use_rs1;
    logic        use_rs2;
    logic        is_imm;
    logic        can_issue;

    // Decode of the held word
    always_comb begin
        fu      = FU_ALU;
        alu_op  = OP_NONE;
        div_rem = 1'b0;
        writes  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        is_imm  = 1'b0;
        if (held[6:0] == OPC_OP_IMM && held[14:12] == 3'b000) begin   // ADDI
            alu_op  = OP_ADD;
            writes  = 1'b1;
            use_rs1 = 1'b1;
            is_imm  = 1'b1;
        end else if (held[6:0] == OPC_OP) begin
            writes  = 1'b1;
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            case ({held[31:25], held[14:12]})
                {F7_BASE, 3'b000}:   alu_op = OP_ADD;
                {F7_ALT, 3'b000}:    alu_op = OP_SUB;
                {F7_BASE, 3'b111}:   alu_op = OP_AND;
                {F7_BASE, 3'b110}:   alu_op = OP_OR;
                {F7_BASE, 3'b100}:   alu_op = OP_XOR;
                {F7_BASE, 3'b010}:   alu_op = OP_SLT;
                {F7_MULDIV, 3'b000}: fu = FU_MUL;
                {F7_MULDIV, 3'b101}: fu = FU_DIV;
                {F7_MULDIV, 3'b111}: begin
                    fu      = FU_DIV;
                    div_rem = 1'b1;
                end
                default: begin                   // Retire as a no-op
                    writes  = 1'b0;
                    use_rs1 = 1'b0;
                    use_rs2 = 1'b0;
                end
            endcase
        end
    end

    assign rs1             = held[19:15];
    assign rs2             = held[24:20];
    assign alloc_dest      = held[11:7];
    assign alloc_reg_write = writes && held[11:7] != 5'd0;   // x0 never marked pending

    assign can_issue = state == DS_HELD && !flush && !full
                     && !(use_rs1 && pending_mask[rs1])
                     && !(use_rs2 && pending_mask[rs2])
                     && !(fu == FU_DIV && div_busy);

    assign inst_ready = state == DS_EMPTY;
    assign alloc      = can_issue;
    assign alu_issue  = can_issue && fu == FU_ALU;
    assign mul_issue  = can_issue && fu == FU_MUL;
    assign div_issue  = can_issue && fu == FU_DIV;
    assign issue_tag  = alloc_tag;       // Tail slot goes with the issue
    assign op_a       = rs1_data;
    assign op_b       = is_imm ? {{(`XLEN-12){held[31]}}, held[31:20]} : rs2_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= DS_EMPTY;
        end else if (flush) begin
            state <= DS_EMPTY;           // Drop the held instruction
        end else begin
            case (state)
                DS_EMPTY: if (inst_valid) state <= DS_HELD;
                DS_HELD:  if (can_issue) state <= DS_EMPTY;
                default:  state <= DS_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DS_EMPTY && inst_valid) begin
            held <= inst;
        end
    end

endmodule

`default_nettype wire

// File: hw/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_macros.svh"

module div_unit (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    flush,
    input  wire                    issue,
    input  wire                    rem,       // Return remainder
    input  wire  [`XLEN-1:0]       a,         // Dividend
    input  wire  [`XLEN-1:0]       b,         // Divisor
    input  wire  rob_pkg::rob_tag_t tag,
    output logic                   busy,
    output logic                   done,
    output rob_pkg::rob_tag_t      done_tag,
    output logic [`XLEN-1:0]       value
);

    localparam int STEP_W = $clog2(`XLEN) + 1;

    logic [STEP_W-1:0] step;            // Shift-subtract steps taken
    logic [`XLEN-1:0]  quo;             // Dividend shifts out, quotient in
    logic [`XLEN-1:0]  part;            // Partial remainder
    logic [`XLEN-1:0]  divisor;
    logic              want_rem;
    logic [`XLEN:0]    trial;
    logic              stepping;

    assign trial    = {part, quo[`XLEN-1]} - {1'b0, divisor};
    assign stepping = busy && step != STEP_W'(`XLEN);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else if (flush) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (issue) begin
                busy <= 1'b1;
                step <= '0;
            end else if (stepping) begin
                step <= step + 1'b1;
            end else if (busy) begin    // Finishing cycle
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // A zero divisor never fails the trial, so the quotient fills with ones
    // and the dividend ends up in the remainder
    always_ff @(posedge clk) begin
        if (issue) begin
            quo      <= a;
            part     <= '0;
            divisor  <= b;
            want_rem <= rem;
            done_tag <= tag;
        end else if (stepping) begin
            if (!trial[`XLEN]) begin    // Fits, keep difference
                part <= trial[`XLEN-1:0];
                quo  <= {quo[`XLEN-2:0], 1'b1};
            end else begin
                part <= {part[`XLEN-2:0], quo[`XLEN-1]};
                quo  <= {quo[`XLEN-2:0], 1'b0};
            end
        end else if (busy) begin
            value <= want_rem ? part : quo;
        end
    end

endmodule

`default_nettype wire

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // ALU operations after decode
    typedef enum logic [2:0] {
        OP_ADD,     // ADD and ADDI
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,     // Signed compare
        OP_NONE     // Unsupported encoding, result zero
    } alu_op_e;

    // Target execution unit
    typedef enum logic [1:0] {
        FU_ALU,
        FU_MUL,
        FU_DIV
    } fu_sel_e;

    // Dispatch holding slot
    typedef enum logic [1:0] {
        DS_EMPTY,   // Slot free, accepting
        DS_HELD     // Waiting on hazards or resources
    } disp_state_e;

endpackage

`default_nettype wire

// File: hw/mul_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_macros.svh"

module mul_pipe (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    flush,
    input  wire                    issue,
    input  wire  [`XLEN-1:0]       a,
    input  wire  [`XLEN-1:0]       b,
    input  wire  rob_pkg::rob_tag_t tag,
    output logic                   done,
    output rob_pkg::rob_tag_t      done_tag,
    output logic [`XLEN-1:0]       value
);
    import rob_pkg::*;

    logic [`MUL_STAGES-1:0] stage_valid;
    rob_tag_t               stage_tag [`MUL_STAGES];
    logic [`XLEN-1:0]       opnd_a;                      // Stage 0 operands
    logic [`XLEN-1:0]       opnd_b;
    logic [`XLEN-1:0]       prod [1:`MUL_STAGES-1];      // Low product from stage 1 on

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_valid <= '0;
        end else if (flush) begin
            stage_valid <= '0;          // Drop all products in flight
        end else begin
            stage_valid <= {stage_valid[`MUL_STAGES-2:0], issue};
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            opnd_a <= a;
            opnd_b <= b;
        end
        stage_tag[0] <= tag;
        prod[1]      <= opnd_a * opnd_b;     // Truncated to XLEN
        for (int s = 1; s < `MUL_STAGES; s++) begin
            stage_tag[s] <= stage_tag[s-1];
        end
        for (int s = 2; s < `MUL_STAGES; s++) begin
            prod[s] <= prod[s-1];
        end
    end

    assign done     = stage_valid[`MUL_STAGES-1];
    assign done_tag = stage_tag[`MUL_STAGES-1];
    assign value    = prod[`MUL_STAGES-1];

endmodule

`default_nettype wire

// File: hw/ooo_backend.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_macros.svh"

module ooo_backend (
    input  wire              clk,
    input  wire              rst,
    input  wire              flush,
    input  wire  [31:0]      inst,
    input  wire              inst_valid,
    output logic             inst_ready,
    output logic             commit_valid,
    output logic [4:0]       commit_dest,
    output logic [`XLEN-1:0] commit_value,
    output logic             commit_reg_write
);
    import rob_pkg::*;
    import isa_pkg::*;

    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [`XLEN-1:0]     rs1_data;
    logic [`XLEN-1:0]     rs2_data;
    logic [`NUM_REGS-1:0] pending_mask;
    logic                 full;
    rob_tag_t             alloc_tag;
    logic                 alloc;
    logic [4:0]           alloc_dest;
    logic                 alloc_reg_write;
    logic                 alu_issue;
    alu_op_e              alu_op;
    logic                 mul_issue;
    logic                 div_issue;
    logic                 div_rem;
    logic                 div_busy;
    logic [`XLEN-1:0]     op_a;
    logic [`XLEN-1:0]     op_b;
    rob_tag_t             issue_tag;
    logic                 alu_done;
    rob_tag_t             alu_tag;
    logic [`XLEN-1:0]     alu_value;
    logic                 mul_done;
    rob_tag_t             mul_tag;
    logic [`XLEN-1:0]     mul_value;
    logic                 div_done;
    rob_tag_t             div_tag;
    logic [`XLEN-1:0]     div_value;

    dispatch_ctrl u_dispatch (
        .clk, .rst, .flush, .inst, .inst_valid, .pending_mask, .full, .alloc_tag,
        .div_busy, .rs1_data, .rs2_data, .inst_ready, .rs1, .rs2, .alloc, .alloc_dest,
        .alloc_reg_write, .alu_issue, .alu_op, .mul_issue, .div_issue, .div_rem,
        .op_a, .op_b, .issue_tag
    );

    arch_regfile u_regfile (
        .clk, .rst, .rs1, .rs2,
        .wr_en   (commit_valid & commit_reg_write),   // Retire edge write
        .wr_addr (commit_dest),
        .wr_data (commit_value),
        .rs1_data, .rs2_data
    );

    alu_unit u_alu (
        .clk, .rst, .flush, .issue(alu_issue), .op(alu_op), .a(op_a), .b(op_b),
        .tag(issue_tag), .done(alu_done), .done_tag(alu_tag), .value(alu_value)
    );

    mul_pipe u_mul (
        .clk, .rst, .flush, .issue(mul_issue), .a(op_a), .b(op_b),
        .tag(issue_tag), .done(mul_done), .done_tag(mul_tag), .value(mul_value)
    );

    div_unit u_div (
        .clk, .rst, .flush, .issue(div_issue), .rem(div_rem), .a(op_a), .b(op_b),
        .tag(issue_tag), .busy(div_busy), .done(div_done), .done_tag(div_tag),
        .value(div_value)
    );

    reorder_buffer u_rob (
        .clk, .rst, .flush, .alloc, .alloc_dest, .alloc_reg_write,
        .alu_done, .alu_tag, .alu_value, .mul_done, .mul_tag, .mul_value,
        .div_done, .div_tag, .div_value, .alloc_tag, .full, .pending_mask,
        .commit_valid, .commit_dest, .commit_value, .commit_reg_write
    );

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_macros.svh"

module reorder_buffer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    flush,
    input  wire                    alloc,
    input  wire  [4:0]             alloc_dest,
    input  wire                    alloc_reg_write,
    input  wire                    alu_done,
    input  wire  rob_pkg::rob_tag_t alu_tag,
    input  wire  [`XLEN-1:0]       alu_value,
    input  wire                    mul_done,
    input  wire  rob_pkg::rob_tag_t mul_tag,
    input  wire  [`XLEN-1:0]       mul_value,
    input  wire                    div_done,
    input  wire  rob_pkg::rob_tag_t div_tag,
    input  wire  [`XLEN-1:0]       div_value,
    output rob_pkg::rob_tag_t      alloc_tag,
    output logic                   full,
    output logic [`NUM_REGS-1:0]   pending_mask,
    output logic                   commit_valid,
    output logic [4:0]             commit_dest,
    output logic [`XLEN-1:0]       commit_value,
    output logic                   commit_reg_write
);
    import rob_pkg::*;

    logic [`ROB_DEPTH-1:0] ent_valid;           // Slot is live
    logic [`ROB_DEPTH-1:0] ent_ready;           // Result has come back
    logic [`ROB_DEPTH-1:0] ent_write;
    logic [4:0]            ent_dest  [`ROB_DEPTH];
    logic [`XLEN-1:0]      ent_value [`ROB_DEPTH];
    rob_tag_t              head;                // Oldest entry
    rob_tag_t              tail;                // Next free slot
    rob_count_t            count;
    logic                  retire;

    assign alloc_tag = tail;
    assign full      = count == rob_count_t'(`ROB_DEPTH);
    assign retire    = ent_valid[head] && ent_ready[head];

    // Commit is the head seen combinationally, taken on the next edge
    assign commit_valid     = retire && !flush;
    assign commit_dest      = ent_dest[head];
    assign commit_value     = ent_value[head];
    assign commit_reg_write = ent_write[head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            ent_ready <= '0;
        end else if (flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
        end else begin
            if (alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_ready[tail] <= 1'b0;
                tail            <= tail + 1'b1;   // Wraps at ROB_DEPTH
            end
            if (alu_done) ent_ready[alu_tag] <= 1'b1;
            if (mul_done) ent_ready[mul_tag] <= 1'b1;
            if (div_done) ent_ready[div_tag] <= 1'b1;
            if (retire) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            count <= count + rob_count_t'(alloc) - rob_count_t'(retire);
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_dest[tail]  <= alloc_dest;
            ent_write[tail] <= alloc_reg_write;
        end
        if (alu_done) ent_value[alu_tag] <= alu_value;   // Tags never collide
        if (mul_done) ent_value[mul_tag] <= mul_value;
        if (div_done) ent_value[div_tag] <= div_value;
    end

    // Destinations still owed by live entries
    always_comb begin
        pending_mask = '0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (ent_valid[i] && ent_write[i]) begin
                pending_mask[ent_dest[i]] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_pkg.sv
`default_nettype none

`include "backend_macros.svh"

package rob_pkg;

    // Slot index, handed out at allocation and returned by every unit
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // One bit wider than a tag so a full buffer is distinct from empty
    typedef logic [`ROB_TAG_W:0] rob_count_t;

endpackage

`default_nettype wire

// File: tests/ooo_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_macros.svh"

module ooo_backend_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;          // Input skew after the rising edge
    localparam int IDLE_CYCLES = 40;          // Quiet window after a flush that outlasts a divide
    localparam int N_CONST     = 16;
    localparam int N_RAND_ALU  = 40;
    localparam int N_ORDER     = 5;
    localparam int N_MD_FIXED  = 7;
    localparam int N_RAND_MD   = 24;
    localparam int N_ILLEGAL   = 6;
    localparam int N_FLUSH     = 8;
    localparam int N_DROPPED   = 5;           // Accepted ahead of the flush pulse
    localparam int NUM_INST    = N_CONST + N_RAND_ALU + N_ORDER + N_MD_FIXED + N_RAND_MD
                               + N_ILLEGAL + N_FLUSH;
    localparam int WATCHDOG_NS = NUM_INST * 40 * CLK_PERIOD + (IDLE_CYCLES + 100) * CLK_PERIOD;

    logic              clk;
    logic              rst;
    logic              flush;
    logic [31:0]       inst;
    logic              inst_valid;
    logic              inst_ready;
    logic              commit_valid;
    logic [4:0]        commit_dest;
    logic [`XLEN-1:0]  commit_value;
    logic              commit_reg_write;

    logic [`XLEN-1:0]  spec_regs [`NUM_REGS];   // Model state in program order
    logic [`XLEN-1:0]  arch_regs [`NUM_REGS];   // Model state as committed
    logic [37:0]       exp_q [$];               // {reg_write, dest, value}
    int                committed;
    int                discarded;               // Dropped by flush
    integer            seed;

    ooo_backend UUT (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .inst             (inst),
        .inst_valid       (inst_valid),
        .inst_ready       (inst_ready),
        .commit_valid     (commit_valid),
        .commit_dest      (commit_dest),
        .commit_value     (commit_value),
        .commit_reg_write (commit_reg_write)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // Six register-register ALU ops
    function automatic logic [31:0] alu_pick(input logic [2:0] sel, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        case (sel)
            3'd0:    return rtype(7'h00, 3'b000, rd, rs1, rs2);   // ADD
            3'd1:    return rtype(7'h20, 3'b000, rd, rs1, rs2);   // SUB
            3'd2:    return rtype(7'h00, 3'b111, rd, rs1, rs2);   // AND
            3'd3:    return rtype(7'h00, 3'b110, rd, rs1, rs2);   // OR
            3'd4:    return rtype(7'h00, 3'b100, rd, rs1, rs2);   // XOR
            default: return rtype(7'h00, 3'b010, rd, rs1, rs2);   // SLT
        endcase
    endfunction

    function automatic logic [31:0] muldiv_pick(input logic [1:0] sel, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        case (sel)
            2'd0:    return rtype(7'h01, 3'b000, rd, rs1, rs2);   // MUL
            2'd1:    return rtype(7'h01, 3'b101, rd, rs1, rs2);   // DIVU
            default: return rtype(7'h01, 3'b111, rd, rs1, rs2);   // REMU
        endcase
    endfunction

    // Expected {writes, value} straight from the RV32 field rules
    function automatic logic [32:0] ref_result(input logic [31:0] word,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [6:0]  opcode;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm;
        opcode = word[6:0];
        f3     = word[14:12];
        f7     = word[31:25];
        imm    = {{20{word[31]}}, word[31:20]};
        if (opcode == 7'b0010011 && f3 == 3'b000) begin
            return {1'b1, a + imm};                   // ADDI
        end
        if (opcode != 7'b0110011) begin
            return {1'b0, 32'd0};
        end
        case ({f7, f3})
            {7'h00, 3'b000}: return {1'b1, a + b};
            {7'h20, 3'b000}: return {1'b1, a - b};
            {7'h00, 3'b111}: return {1'b1, a & b};
            {7'h00, 3'b110}: return {1'b1, a | b};
            {7'h00, 3'b100}: return {1'b1, a ^ b};
            {7'h00, 3'b010}: return {1'b1, 31'd0, $signed(a) < $signed(b)};
            {7'h01, 3'b000}: return {1'b1, a * b};    // Low half only
            {7'h01, 3'b101}: return {1'b1, (b == 32'd0) ? 32'hFFFF_FFFF : a / b};
            {7'h01, 3'b111}: return {1'b1, (b == 32'd0) ? a : a % b};
            default:         return {1'b0, 32'd0};    // Retires as a no-op
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // Offer one word, then log its expected commit once it is taken
    task automatic issue_inst(input logic [31:0] word);
        logic [32:0] res;
        logic [4:0]  rd;
        logic        wr;
        inst       = word;
        inst_valid = 1'b1;
        while (!inst_ready) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(posedge clk);                               // Accepted here
        #DRIVE_DELAY;
        inst_valid = 1'b0;
        res = ref_result(word, spec_regs[word[19:15]], spec_regs[word[24:20]]);
        rd  = word[11:7];
        wr  = res[32] && rd != 5'd0;
        if (wr) spec_regs[rd] = res[31:0];
        exp_q.push_back({wr, rd, res[31:0]});
    endtask

    task automatic wait_drain;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic pulse_flush;
        flush = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b0;
        discarded += exp_q.size();
        exp_q.delete();
        for (int i = 0; i < `NUM_REGS; i++) begin
            spec_regs[i] = arch_regs[i];              // Back to committed state
        end
    endtask

    // Commit level is stable mid-cycle and retires on the next edge
    always @(negedge clk) begin : commit_check
        logic [37:0] e;
        if (!rst && commit_valid) begin
            assert (exp_q.size() != 0)
                else abort_run($sformatf("Commit at %0d ns with no instruction outstanding",
                                         $time));
            e = exp_q.pop_front();
            assert (commit_dest === e[36:32])
                else abort_run($sformatf("Error at %0d ns: commit_dest = %0d, expected %0d",
                                         $time, commit_dest, e[36:32]));
            assert (commit_reg_write === e[37])
                else abort_run($sformatf("Error at %0d ns: commit_reg_write = %b, expected %b",
                                         $time, commit_reg_write, e[37]));
            assert (commit_value === e[31:0])
                else abort_run($sformatf("Error at %0d ns: commit_value = %h, expected %h",
                                         $time, commit_value, e[31:0]));
            if (e[37]) arch_regs[e[36:32]] = e[31:0];
            committed++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("Timeout: commits stopped arriving before all instructions retired");
    end

    initial begin : stimulus
        logic [31:0] r;
        rst        = 1'b1;
        flush      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        committed  = 0;
        discarded  = 0;
        seed       = 43;
        for (int i = 0; i < `NUM_REGS; i++) begin
            spec_regs[i] = '0;
            arch_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Constants with negative immediates and an x0 target
        issue_inst(addi(5'd1, 5'd0, 12'd100));
        issue_inst(addi(5'd2, 5'd0, 12'hFF9));        // -7
        issue_inst(addi(5'd3, 5'd0, 12'd2047));
        issue_inst(addi(5'd4, 5'd0, 12'h800));        // -2048
        issue_inst(addi(5'd5, 5'd0, 12'd37));
        issue_inst(addi(5'd6, 5'd0, 12'hFFF));
        issue_inst(addi(5'd7, 5'd0, 12'd1234));
        issue_inst(addi(5'd8, 5'd0, 12'hED4));        // -300
        issue_inst(addi(5'd0, 5'd0, 12'd55));         // Discarded write
        issue_inst(addi(5'd9, 5'd1, 12'hF6A));
        issue_inst(rtype(7'h00, 3'b000, 5'd10, 5'd0, 5'd3));   // x0 reads zero
        for (int i = 0; i < 5; i++) begin
            r = $random(seed);
            issue_inst(addi(5'(12 + i), 5'd0, r[31:20]));
        end

        // Dependent chains through x1..x8
        for (int i = 0; i < N_RAND_ALU; i++) begin
            r = $random(seed);
            if (r[2:1] == 2'b11) begin
                issue_inst(addi(5'd1 + r[5:3], 5'd1 + r[8:6], r[31:20]));
            end else begin
                issue_inst(alu_pick(r[2:0], 5'd1 + r[5:3], 5'd1 + r[8:6], 5'd1 + r[11:9]));
            end
        end

        // Slow divide ahead of fast independent work
        issue_inst(muldiv_pick(2'd1, 5'd13, 5'd3, 5'd5));
        issue_inst(rtype(7'h00, 3'b000, 5'd14, 5'd1, 5'd2));
        issue_inst(muldiv_pick(2'd0, 5'd15, 5'd6, 5'd8));
        issue_inst(rtype(7'h00, 3'b100, 5'd16, 5'd7, 5'd4));
        issue_inst(rtype(7'h00, 3'b000, 5'd17, 5'd13, 5'd14));

        // Multiplies back to back, zero divisors, then random M ops
        issue_inst(muldiv_pick(2'd0, 5'd18, 5'd3, 5'd7));
        issue_inst(muldiv_pick(2'd0, 5'd19, 5'd18, 5'd18));
        issue_inst(muldiv_pick(2'd0, 5'd20, 5'd1, 5'd2));
        issue_inst(muldiv_pick(2'd0, 5'd21, 5'd3, 5'd4));
        issue_inst(muldiv_pick(2'd0, 5'd22, 5'd5, 5'd6));
        issue_inst(muldiv_pick(2'd1, 5'd23, 5'd3, 5'd0));
        issue_inst(muldiv_pick(2'd2, 5'd24, 5'd8, 5'd0));
        for (int i = 0; i < N_RAND_MD; i++) begin
            r = $random(seed);
            issue_inst(muldiv_pick(r[1:0], 5'd18 + r[4:2], r[9:5], r[14:10]));
        end

        // Unsupported encodings leave their targets alone
        issue_inst({12'd4, 5'd1, 3'b010, 5'd5, 7'b0000011});   // Load
        issue_inst(rtype(7'h20, 3'b111, 5'd6, 5'd1, 5'd2));
        issue_inst({12'd3, 5'd7, 3'b001, 5'd7, 7'b0010011});   // Shift immediate
        issue_inst(rtype(7'h01, 3'b100, 5'd8, 5'd3, 5'd4));    // Signed DIV
        issue_inst(rtype(7'h00, 3'b000, 5'd9, 5'd5, 5'd6));
        issue_inst(rtype(7'h00, 3'b100, 5'd10, 5'd7, 5'd8));

        // Flush with a divide at the head and one instruction held
        wait_drain();
        issue_inst(muldiv_pick(2'd1, 5'd26, 5'd19, 5'd3));
        issue_inst(muldiv_pick(2'd0, 5'd27, 5'd3, 5'd4));
        issue_inst(rtype(7'h00, 3'b000, 5'd28, 5'd1, 5'd1));
        issue_inst(addi(5'd1, 5'd0, 12'd77));
        issue_inst(rtype(7'h00, 3'b000, 5'd29, 5'd26, 5'd2));  // Waits on x26
        pulse_flush();
        repeat (IDLE_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        issue_inst(rtype(7'h00, 3'b000, 5'd30, 5'd1, 5'd2));
        issue_inst(rtype(7'h20, 3'b000, 5'd31, 5'd27, 5'd1));
        issue_inst(muldiv_pick(2'd0, 5'd28, 5'd1, 5'd3));

        wait_drain();
        repeat (10) @(posedge clk);                   // Catch stray commits
        if (discarded == N_DROPPED && committed == NUM_INST - N_DROPPED) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("Commit count does not match the instructions that survive the flush");
        end
    end

endmodule

`default_nettype wire
